/* flist.f */
hdl/exPkg.sv
hdl/exStageIf.sv
hdl/exDecode.sv
hdl/exExecute.sv
hdl/exResult.sv
hdl/exCore.sv
verif/exCore_properties.sv
verif/exCore_tb.sv

/* verif/exCore_tb.sv */
/*
	Directed testbench for the integer execute back end
	Drives micro-ops, models a 256-word memory with random
	back-pressure and response delay, and checks writebacks,
	T, DLR/DHR and the sticky fault against rule-based values
*/
`default_nettype none

module exCore_tb;

	localparam int addrWidth = 32;
	localparam int dw = exPkg::dataWidth;
	localparam int rw = exPkg::regIdWidth;
	localparam int iw = exPkg::immWidth;
	// Worst case per test: reset, ALU, compare, multiply, memory, fault
	localparam int timeoutCycles = 20 + 40 + 90 + 60 + 240 + 60;

	typedef struct packed {
		logic [rw-1:0] dest;
		logic [dw-1:0] data;
		logic [31:0] at;	// Expected edge, 0 means response edge
	} wbExp;

	logic clock;
	logic rst;
	logic opValid;
	exPkg::exOpcode opCmd;
	exPkg::exCond opCond;
	logic [1:0] opIxt;
	logic [dw-1:0] opSrcA;
	logic [dw-1:0] opSrcB;
	logic [dw-1:0] opSrcC;
	logic [iw-1:0] opImm;
	logic [rw-1:0] opDest;
	logic opReady;
	logic memReqValid;
	logic memReqReady;
	logic memReqWrite;
	logic [addrWidth-1:0] memReqAddr;
	logic [dw-1:0] memReqData;
	logic memRspValid;
	logic [dw-1:0] memRspData;
	logic memRspFault;
	logic wbValid;
	logic [rw-1:0] wbDest;
	logic [dw-1:0] wbData;
	logic tFlag;
	logic [dw-1:0] dlr;
	logic [dw-1:0] dhr;
	logic fault;

	int cycle = 0;	// Rising edges so far
	int errors = 0;
	int checks = 0;
	int seed = 64192;
	int acceptEdge = 0;	// Edge that took the last micro-op
	int memOpsSent = 0;
	int rspCount = 0;
	int lastRspEdge = 0;	// Edge that samples the last response
	wbExp expQ[$];	// Pending writebacks in order
	logic [addrWidth:0] addrQ[$];	// {write, address} per request
	logic [dw-1:0] mem [256];
	logic faultOn = 1'b0;
	logic [addrWidth-1:0] faultAddr = '0;

	exCore #(.addrWidth(addrWidth)) i_dut (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin : watchdog
		while (cycle < timeoutCycles) begin
			@(posedge clock);
			cycle++;
		end
		$display("Timeout after %0d cycles, the run did not finish", cycle);
		$display("Testbench failed");
		$finish;
	end

	task automatic checkData(input string name, input logic [dw-1:0] got,
		input logic [dw-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkId(input string name, input logic [rw-1:0] got,
		input logic [rw-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	// Writeback monitor on the falling edge
	always @(negedge clock) begin : wbMonitor
		wbExp e;
		int expAt;
		if (wbValid === 1'b1) begin
			if (expQ.size() == 0) begin
				errors++;
				$display("Unexpected writeback to register %0d at %0t", wbDest, $time);
			end else begin
				e = expQ.pop_front();
				expAt = (e.at == 0) ? lastRspEdge : e.at;	// Loads end at the response
				checkId("wbDest", wbDest, e.dest);
				checkData("wbData", wbData, e.data);
				checks++;
				if (cycle != expAt) begin
					errors++;
					$display("Writeback to register %0d came after edge %0d, not edge %0d",
						wbDest, cycle, expAt);
				end
			end
		end
	end

	// Memory model with random back-pressure and response delay
	initial begin : memResponder
		int i;
		int delay;
		logic reqWrite;
		logic [addrWidth-1:0] reqAddr;
		logic [dw-1:0] reqData;
		logic [addrWidth:0] expReq;
		for (i = 0; i < 256; i++)
			mem[i] = {24'hA5A5A5, i[7:0], ~i[7:0], 24'h5A5A5A};
		memReqReady = 1'b0;
		memRspValid = 1'b0;
		memRspData = '0;
		memRspFault = 1'b0;
		forever begin
			@(posedge clock);
			#10;
			memRspValid = 1'b0;
			memRspFault = 1'b0;
			memReqReady = ($random(seed) & 3) != 0;	// Ready three times in four
			@(negedge clock);
			if (memReqValid === 1'b1 && memReqReady) begin
				reqWrite = memReqWrite;
				reqAddr = memReqAddr;
				reqData = memReqData;
				if (addrQ.size() == 0) begin
					errors++;
					$display("Memory request at %0t with no memory micro-op sent", $time);
				end else begin
					expReq = addrQ.pop_front();
					checkFlag("memReqWrite", reqWrite, expReq[addrWidth]);
					checkData("memReqAddr", {{(dw-addrWidth){1'b0}}, reqAddr},
						{{(dw-addrWidth){1'b0}}, expReq[addrWidth-1:0]});
				end
				delay = $random(seed) & 3;
				@(posedge clock);	// Request transfer edge
				#10;
				memReqReady = 1'b0;
				repeat (delay) begin
					@(posedge clock);
					#10;
				end
				memRspFault = faultOn && (reqAddr == faultAddr);
				if (reqWrite && !memRspFault)
					mem[reqAddr[10:3]] = reqData;	// 64-bit words
				memRspData = memRspFault ? '0 : mem[reqAddr[10:3]];
				memRspValid = 1'b1;	// One cycle
				lastRspEdge = cycle + 1;
				rspCount++;
			end
		end
	end

	task automatic sendOp(
		input exPkg::exOpcode cmd,
		input exPkg::exCond cond,
		input logic [1:0] ixt,
		input logic [dw-1:0] a,
		input logic [dw-1:0] b,
		input logic [dw-1:0] c,
		input logic [iw-1:0] imm,
		input logic [rw-1:0] dest
	);
		opValid = 1'b1;
		opCmd = cmd;
		opCond = cond;
		opIxt = ixt;
		opSrcA = a;
		opSrcB = b;
		opSrcC = c;
		opImm = imm;
		opDest = dest;
		@(negedge clock);
		while (opReady !== 1'b1)
			@(negedge clock);
		acceptEdge = cycle + 1;
		@(posedge clock);
		#10;
		opValid = 1'b0;
	endtask

	task automatic expectWb(input logic [rw-1:0] dest, input logic [dw-1:0] data,
		input int at);
		wbExp e;
		e.dest = dest;
		e.data = data;
		e.at = at;
		expQ.push_back(e);
	endtask

	task automatic aluOp(input exPkg::exOpcode cmd, input logic [dw-1:0] a,
		input logic [dw-1:0] b, input logic [dw-1:0] exp, input logic [rw-1:0] dest);
		sendOp(cmd, exPkg::ALWAYS, 2'd0, a, b, '0, '0, dest);
		expectWb(dest, exp, acceptEdge + 3);
	endtask

	task automatic memOp(input logic write, input logic [dw-1:0] a, input logic [dw-1:0] b,
		input logic [dw-1:0] c, input logic [iw-1:0] imm, input logic [rw-1:0] dest);
		logic [dw-1:0] addr;
		addr = a + b + {{(dw-iw){imm[iw-1]}}, imm};	// Base plus index plus immediate
		sendOp(write ? exPkg::STORE : exPkg::LOAD, exPkg::ALWAYS, 2'd0, a, b, c, imm, dest);
		memOpsSent++;
		addrQ.push_back({write, addr[addrWidth-1:0]});
	endtask

	// Wait for all writebacks and responses, then settle
	task automatic drain();
		@(negedge clock);
		while (expQ.size() != 0 || rspCount != memOpsSent)
			@(negedge clock);
		repeat (4) @(posedge clock);
		#10;
	endtask

	task automatic waitEdge(input int n);
		@(negedge clock);
		while (cycle < n)
			@(negedge clock);
	endtask

	task automatic resetValues();
		checkFlag("wbValid", wbValid, 1'b0);
		checkFlag("memReqValid", memReqValid, 1'b0);
		checkFlag("fault", fault, 1'b0);
		checkFlag("tFlag", tFlag, 1'b0);
		checkData("dlr", dlr, '0);
		checkData("dhr", dhr, '0);
	endtask

	task automatic aluOps();
		logic [dw-1:0] a;
		logic [dw-1:0] b;
		a = 64'h0123_4567_89AB_CDEF;
		b = 64'hFEDC_BA98_7654_3211;
		aluOp(exPkg::ADD, a, b, a + b, 6'd1);	// Back to back
		aluOp(exPkg::SUB, a, b, a - b, 6'd2);
		aluOp(exPkg::AND, a, b, a & b, 6'd3);
		aluOp(exPkg::OR, a, b, a | b, 6'd4);
		aluOp(exPkg::XOR, a, b, a ^ b, 6'd5);
		sendOp(exPkg::MOVI, exPkg::ALWAYS, 2'd0, a, b, '0, 33'h1_FFFF_FF00, 6'd6);
		expectWb(6'd6, 64'hFFFF_FFFF_FFFF_FF00, acceptEdge + 3);	// -256
		sendOp(exPkg::MOVI, exPkg::ALWAYS, 2'd0, a, b, '0, 33'h0_8000_0000, 6'd7);
		expectWb(6'd7, 64'h0000_0000_8000_0000, acceptEdge + 3);
		drain();
	endtask

	task automatic compareAndPredicate();
		sendOp(exPkg::CMPEQ, exPkg::ALWAYS, 2'd0, 64'd5, 64'd5, '0, '0, 6'd0);
		sendOp(exPkg::ADD, exPkg::IFTRUE, 2'd0, 64'd10, 64'd20, '0, '0, 6'd10);
		expectWb(6'd10, 64'd30, acceptEdge + 3);	// Needs the new T
		sendOp(exPkg::ADD, exPkg::IFFALSE, 2'd0, 64'd1, 64'd2, '0, '0, 6'd11);
		sendOp(exPkg::ADD, exPkg::NEVER, 2'd0, 64'd3, 64'd4, '0, '0, 6'd12);
		drain();
		checkFlag("tFlag", tFlag, 1'b1);
		// Signed, so -1 is not greater than 1
		sendOp(exPkg::CMPGT, exPkg::ALWAYS, 2'd0, '1, 64'd1, '0, '0, 6'd0);
		sendOp(exPkg::XOR, exPkg::IFFALSE, 2'd0, 64'hF0, 64'h3C, '0, '0, 6'd13);
		expectWb(6'd13, 64'hCC, acceptEdge + 3);
		sendOp(exPkg::XOR, exPkg::IFTRUE, 2'd0, 64'hF0, 64'h3C, '0, '0, 6'd14);
		sendOp(exPkg::SUB, exPkg::NEVER, 2'd0, 64'd9, 64'd1, '0, '0, 6'd15);
		drain();
		checkFlag("tFlag", tFlag, 1'b0);
		// 7 > -3 and T moves on the writeback edge
		sendOp(exPkg::CMPGT, exPkg::ALWAYS, 2'd0, 64'd7, 64'hFFFF_FFFF_FFFF_FFFD, '0, '0, 6'd0);
		waitEdge(acceptEdge + 2);
		checkFlag("tFlag", tFlag, 1'b0);
		waitEdge(acceptEdge + 3);
		checkFlag("tFlag", tFlag, 1'b1);
		drain();
	endtask

	task automatic multiplyModes();
		logic [dw-1:0] a;
		logic [dw-1:0] b;
		logic [dw-1:0] sProd;
		logic [dw-1:0] uProd;
		a = 64'h1234_5678_FFFF_FFFD;	// Low word -3
		b = 64'hDEAD_BEEF_0000_0007;	// Low word 7
		// Even modes multiply signed words, odd modes unsigned
		sProd = {{32{a[31]}}, a[31:0]} * {{32{b[31]}}, b[31:0]};
		uProd = {32'b0, a[31:0]} * {32'b0, b[31:0]};
		sendOp(exPkg::MUL, exPkg::ALWAYS, 2'd0, a, b, '0, '0, 6'd20);
		expectWb(6'd20, {{32{sProd[31]}}, sProd[31:0]}, acceptEdge + 4);
		drain();
		sendOp(exPkg::MUL, exPkg::ALWAYS, 2'd1, a, b, '0, '0, 6'd21);
		expectWb(6'd21, {32'b0, uProd[31:0]}, acceptEdge + 4);
		drain();
		sendOp(exPkg::MUL, exPkg::ALWAYS, 2'd2, a, b, '0, '0, 6'd22);
		drain();
		checkData("dlr", dlr, {32'b0, sProd[31:0]});
		checkData("dhr", dhr, {{32{sProd[63]}}, sProd[63:32]});
		sendOp(exPkg::MUL, exPkg::ALWAYS, 2'd3, a, b, '0, '0, 6'd23);
		drain();
		checkData("dlr", dlr, {32'b0, uProd[31:0]});
		checkData("dhr", dhr, {32'b0, uProd[63:32]});
	endtask

	task automatic memoryRoundTrip();
		logic [dw-1:0] data [4];
		int i;
		for (i = 0; i < 4; i++) begin
			data[i] = {32'hC0DE_0000 + i, 32'hFACE_0000 - i};
			// 0x2000 + 24i - 8
			memOp(1'b1, 64'h2000, 64'(i * 24), data[i], 33'h1_FFFF_FFF8, 6'd0);
		end
		for (i = 0; i < 4; i++) begin
			// Same addresses from another split of base and index
			memOp(1'b0, 64'h1F00, 64'(248 + i * 24), '0, '0, 6'(30 + i));
			expectWb(6'(30 + i), data[i], 0);
		end
		drain();
	endtask

	task automatic faultRecovery();
		faultAddr = 32'h0000_3000;
		faultOn = 1'b1;
		memOp(1'b0, 64'h2F00, 64'h80, '0, 33'h80, 6'd40);	// No writeback
		drain();
		checkFlag("fault", fault, 1'b1);
		faultOn = 1'b0;
		aluOp(exPkg::ADD, 64'd100, 64'd23, 64'd123, 6'd41);
		aluOp(exPkg::SUB, 64'd100, 64'd23, 64'd77, 6'd42);
		drain();
		checkFlag("fault", fault, 1'b1);	// Sticky
	endtask

	initial begin
		rst = 1'b1;
		opValid = 1'b0;
		opCmd = exPkg::NOP;
		opCond = exPkg::ALWAYS;
		opIxt = 2'd0;
		opSrcA = '0;
		opSrcB = '0;
		opSrcC = '0;
		opImm = '0;
		opDest = '0;
		repeat (4) @(posedge clock);
		#10;
		rst = 1'b0;
		resetValues();
		aluOps();
		compareAndPredicate();
		multiplyModes();
		memoryRoundTrip();
		faultRecovery();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/exCore_properties.sv */
/*
	Bound assertions for the execute back end
	Memory request stability, quiet writeback after reset
	and the input stall while EX2 holds
*/
`default_nettype none

module exCore_properties #(
	parameter int addrWidth = 32
) (
	input wire logic clock,
	input wire logic rst,
	input wire logic opReady,
	input wire logic holding,	// EX2 stall
	input wire logic memReqValid,
	input wire logic memReqReady,
	input wire logic memReqWrite,
	input wire logic [addrWidth-1:0] memReqAddr,
	input wire logic [exPkg::dataWidth-1:0] memReqData,
	input wire logic wbValid
);

	reqStable: assert property (@(posedge clock) disable iff (rst)
		memReqValid && !memReqReady |=> memReqValid && $stable(memReqWrite)
			&& $stable(memReqAddr) && $stable(memReqData))
		else $error("memory request dropped or changed before memReqReady");

	wbQuietAfterReset: assert property (@(posedge clock) rst |=> !wbValid)
		else $error("wbValid high in the cycle after reset");

	inputStall: assert property (@(posedge clock) disable iff (rst) holding |-> !opReady)
		else $error("opReady high while EX2 holds");

endmodule

bind exCore exCore_properties #(.addrWidth(addrWidth)) i_props (
	.clock(clock),
	.rst(rst),
	.opReady(opReady),
	.holding(i_result.holding),	// Stall flag inside EX2
	.memReqValid(memReqValid),
	.memReqReady(memReqReady),
	.memReqWrite(memReqWrite),
	.memReqAddr(memReqAddr),
	.memReqData(memReqData),
	.wbValid(wbValid)
);

`default_nettype wire

/* hdl/exCore.sv */
/*
	Integer execute back end, top level
	Decode, EX1 and EX2 in a three-stage pipeline with a single
	memory request/response port and a writeback port
*/
`default_nettype none

module exCore #(
	parameter int addrWidth = 32	// Memory address width
) (
	input wire logic clock,
	input wire logic rst,
	input wire logic opValid,
	input wire exPkg::exOpcode opCmd,
	input wire exPkg::exCond opCond,
	input wire logic [1:0] opIxt,
	input wire logic [exPkg::dataWidth-1:0] opSrcA,
	input wire logic [exPkg::dataWidth-1:0] opSrcB,
	input wire logic [exPkg::dataWidth-1:0] opSrcC,
	input wire logic [exPkg::immWidth-1:0] opImm,
	input wire logic [exPkg::regIdWidth-1:0] opDest,
	output logic opReady,
	output logic memReqValid,
	input wire logic memReqReady,
	output logic memReqWrite,
	output logic [addrWidth-1:0] memReqAddr,
	output logic [exPkg::dataWidth-1:0] memReqData,
	input wire logic memRspValid,
	input wire logic [exPkg::dataWidth-1:0] memRspData,
	input wire logic memRspFault,
	output logic wbValid,
	output logic [exPkg::regIdWidth-1:0] wbDest,
	output logic [exPkg::dataWidth-1:0] wbData,
	output logic tFlag,
	output logic [exPkg::dataWidth-1:0] dlr,
	output logic [exPkg::dataWidth-1:0] dhr,
	output logic fault
);

	logic flagPendingEx;	// Compare in EX1
	logic flagPendingRes;	// Compare in EX2

	exUopIf uopBus ();	// Decode to EX1
	exExecIf execBus ();	// EX1 to EX2

	exDecode i_decode (
		.clock(clock),
		.rst(rst),
		.opValid(opValid),
		.opCmd(opCmd),
		.opCond(opCond),
		.opIxt(opIxt),
		.opSrcA(opSrcA),
		.opSrcB(opSrcB),
		.opSrcC(opSrcC),
		.opImm(opImm),
		.opDest(opDest),
		.opReady(opReady),
		.tFlag(tFlag),
		.flagPendingEx(flagPendingEx),
		.flagPendingRes(flagPendingRes),
		.uopOut(uopBus.source)
	);

	exExecute #(
		.addrWidth(addrWidth)
	) i_execute (
		.clock(clock),
		.rst(rst),
		.uopIn(uopBus.sink),
		.execOut(execBus.source),
		.flagPending(flagPendingEx),
		.memReqValid(memReqValid),
		.memReqWrite(memReqWrite),
		.memReqAddr(memReqAddr),
		.memReqData(memReqData),
		.memReqReady(memReqReady)
	);

	exResult i_result (
		.clock(clock),
		.rst(rst),
		.execIn(execBus.sink),
		.memRspValid(memRspValid),
		.memRspData(memRspData),
		.memRspFault(memRspFault),
		.wbValid(wbValid),
		.wbDest(wbDest),
		.wbData(wbData),
		.tFlag(tFlag),
		.dlr(dlr),
		.dhr(dhr),
		.fault(fault),
		.flagPending(flagPendingRes)
	);

endmodule

`default_nettype wire

/* hdl/exResult.sv */
/*
	EX2 result stage
	Completes what EX1 started: waits for the memory response,
	gives MUL its extra cycle, selects the writeback and updates
	T and DLR/DHR. While it holds, the whole pipeline stalls.
	A faulting access drops its writeback and sets a sticky fault.
*/
`default_nettype none

module exResult (
	input wire logic clock,
	input wire logic rst,
	exExecIf.sink execIn,
	input wire logic memRspValid,
	input wire logic [exPkg::dataWidth-1:0] memRspData,
	input wire logic memRspFault,
	output logic wbValid,
	output logic [exPkg::regIdWidth-1:0] wbDest,
	output logic [exPkg::dataWidth-1:0] wbData,
	output logic tFlag,	// Status T bit
	output logic [exPkg::dataWidth-1:0] dlr,
	output logic [exPkg::dataWidth-1:0] dhr,
	output logic fault,	// Sticky until reset
	output logic flagPending
);

	logic rValid;	// Stage register occupied
	exPkg::exExec r;
	logic [3:0] holdCyc;	// Cycles spent holding
	logic isMemOp;
	logic holding;
	logic done;
	logic rnWrite;
	logic [exPkg::dataWidth-1:0] rnValue;
	logic dWrite;
	logic [exPkg::dataWidth-1:0] dlrNext;
	logic [exPkg::dataWidth-1:0] dhrNext;
	logic tWrite;

	assign isMemOp = r.isLoad || (r.opcode == exPkg::STORE);
	// MUL waits out its first cycle, memory waits for the response
	assign holding = rValid
		&& ((r.isMul && (holdCyc == 4'd0)) || (isMemOp && !memRspValid));
	assign done = rValid && !holding;
	assign execIn.ready = !holding;
	assign flagPending = rValid && ((r.opcode == exPkg::CMPEQ) || (r.opcode == exPkg::CMPGT));

	always_comb begin
		rnWrite = 1'b0;
		rnValue = r.aluRes;
		dWrite = 1'b0;
		dlrNext = {32'b0, r.product[31:0]};	// Low half always zero-extended
		dhrNext = {32'b0, r.product[63:32]};
		tWrite = 1'b0;
		case (r.opcode)
			exPkg::ADD, exPkg::SUB, exPkg::AND, exPkg::OR, exPkg::XOR, exPkg::MOVI:
				rnWrite = 1'b1;
			exPkg::CMPEQ, exPkg::CMPGT:
				tWrite = 1'b1;	// Compare writes T only
			exPkg::LOAD: begin
				rnWrite = !memRspFault;	// No writeback on fault
				rnValue = memRspData;
			end
			exPkg::MUL: begin
				case (r.ixt)
					2'd0: begin
						rnWrite = 1'b1;
						rnValue = {{32{r.product[31]}}, r.product[31:0]};
					end
					2'd1: begin
						rnWrite = 1'b1;
						rnValue = {32'b0, r.product[31:0]};
					end
					2'd2: begin
						dWrite = 1'b1;
						dhrNext = {{32{r.product[63]}}, r.product[63:32]};
					end
					default: dWrite = 1'b1;	// Both halves zero-extended
				endcase
			end
			default: rnWrite = 1'b0;	// NOP, STORE
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			rValid <= 1'b0;
			holdCyc <= 4'd0;
			wbValid <= 1'b0;
			tFlag <= 1'b0;
			dlr <= '0;
			dhr <= '0;
			fault <= 1'b0;
		end else begin
			if (holding)
				holdCyc <= holdCyc + 4'd1;
			else
				holdCyc <= 4'd0;
			if (!holding)
				rValid <= execIn.valid;
			wbValid <= done && rnWrite;	// One-cycle pulse
			if (done && tWrite)
				tFlag <= r.cmpFlag;
			if (done && dWrite) begin
				dlr <= dlrNext;
				dhr <= dhrNext;
			end
			if (done && isMemOp && memRspFault)
				fault <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (!holding)
			r <= execIn.payload;
		if (done && rnWrite) begin
			wbDest <= r.dest;
			wbData <= rnValue;
		end
	end

endmodule

`default_nettype wire

/* hdl/exExecute.sv */
/*
	EX1 execute stage
	ALU, compares, 32x32 multiply and address generation.
	Memory micro-ops issue one request from the stage register
	and move on only once that request has been taken.
*/
`default_nettype none

module exExecute #(
	parameter int addrWidth = 32
) (
	input wire logic clock,
	input wire logic rst,
	exUopIf.sink uopIn,
	exExecIf.source execOut,
	output logic flagPending,	// Compare in this stage
	output logic memReqValid,
	output logic memReqWrite,
	output logic [addrWidth-1:0] memReqAddr,
	output logic [exPkg::dataWidth-1:0] memReqData,
	input wire logic memReqReady
);

	logic sValid;	// Stage register occupied
	exPkg::exUop s;
	logic memFire;
	logic memOk;
	logic [exPkg::dataWidth-1:0] immExt;
	logic [exPkg::dataWidth-1:0] addrSum;
	logic signed [63:0] prodSigned;
	logic [63:0] prodUnsigned;
	exPkg::exExec execNext;

	assign immExt = {{(exPkg::dataWidth-exPkg::immWidth){s.imm[exPkg::immWidth-1]}}, s.imm};
	assign addrSum = s.srcA + s.srcB + immExt;

	// Even modes signed, odd modes unsigned
	assign prodSigned = $signed(s.srcA[31:0]) * $signed(s.srcB[31:0]);
	assign prodUnsigned = {32'b0, s.srcA[31:0]} * {32'b0, s.srcB[31:0]};

	// Request only while EX2 is free, so one access is in flight
	assign memReqValid = sValid && s.isMem && execOut.ready;
	assign memReqWrite = (s.opcode == exPkg::STORE);
	assign memReqAddr = addrSum[addrWidth-1:0];	// Truncated address
	assign memReqData = s.srcC;
	assign memFire = memReqValid && memReqReady;
	assign memOk = !s.isMem || memFire;	// Request taken on this edge

	always_comb begin
		execNext.opcode = s.opcode;
		execNext.ixt = s.ixt;
		execNext.dest = s.dest;
		execNext.aluRes = '0;
		execNext.cmpFlag = 1'b0;
		execNext.product = s.ixt[0] ? prodUnsigned : prodSigned;
		execNext.isLoad = (s.opcode == exPkg::LOAD);
		execNext.isMul = s.isMul;
		case (s.opcode)
			exPkg::ADD: execNext.aluRes = s.srcA + s.srcB;
			exPkg::SUB: execNext.aluRes = s.srcA - s.srcB;
			exPkg::AND: execNext.aluRes = s.srcA & s.srcB;
			exPkg::OR: execNext.aluRes = s.srcA | s.srcB;
			exPkg::XOR: execNext.aluRes = s.srcA ^ s.srcB;
			exPkg::MOVI: execNext.aluRes = immExt;
			exPkg::CMPEQ: begin
				execNext.cmpFlag = (s.srcA == s.srcB);
				execNext.aluRes = {{(exPkg::dataWidth-1){1'b0}}, execNext.cmpFlag};
			end
			exPkg::CMPGT: begin
				execNext.cmpFlag = ($signed(s.srcA) > $signed(s.srcB));
				execNext.aluRes = {{(exPkg::dataWidth-1){1'b0}}, execNext.cmpFlag};
			end
			exPkg::LOAD, exPkg::STORE: execNext.aluRes = addrSum;	// Address
			default: execNext.aluRes = '0;	// NOP, MUL
		endcase
	end

	assign execOut.valid = sValid && memOk;
	assign execOut.payload = execNext;
	assign uopIn.ready = execOut.ready && (!sValid || memOk);	// Stall on EX2 or memory
	assign flagPending = sValid && s.writesFlag;

	always_ff @(posedge clock) begin
		if (rst)
			sValid <= 1'b0;
		else if (uopIn.ready)
			sValid <= uopIn.valid;
	end

	always_ff @(posedge clock) begin
		if (uopIn.ready)
			s <= uopIn.payload;
	end

endmodule

`default_nettype wire

/* hdl/exDecode.sv */
/*
	Decode stage
	Registers the incoming micro-op, checks its predicate against T
	and sets the class flags. A predicated micro-op waits at the
	input while any compare is still ahead of it in the pipeline.
*/
`default_nettype none

module exDecode (
	input wire logic clock,
	input wire logic rst,
	input wire logic opValid,
	input wire exPkg::exOpcode opCmd,
	input wire exPkg::exCond opCond,
	input wire logic [1:0] opIxt,
	input wire logic [exPkg::dataWidth-1:0] opSrcA,
	input wire logic [exPkg::dataWidth-1:0] opSrcB,
	input wire logic [exPkg::dataWidth-1:0] opSrcC,
	input wire logic [exPkg::immWidth-1:0] opImm,
	input wire logic [exPkg::regIdWidth-1:0] opDest,
	output logic opReady,
	input wire logic tFlag,	// Committed T bit
	input wire logic flagPendingEx,	// Compare in EX1
	input wire logic flagPendingRes,	// Compare in EX2
	exUopIf.source uopOut
);

	logic dValid;	// Stage register occupied
	exPkg::exUop dUop;
	exPkg::exUop uopNext;
	logic condPass;
	logic isPredicated;
	logic interlock;

	always_comb begin
		case (opCond)
			exPkg::ALWAYS: condPass = 1'b1;
			exPkg::NEVER: condPass = 1'b0;
			exPkg::IFTRUE: condPass = tFlag;
			default: condPass = !tFlag;	// IFFALSE
		endcase
	end

	assign isPredicated = (opCond == exPkg::IFTRUE) || (opCond == exPkg::IFFALSE);
	// T is stale while any compare sits in decode, EX1 or EX2
	assign interlock = isPredicated
		&& (flagPendingEx || flagPendingRes || (dValid && dUop.writesFlag));
	assign opReady = uopOut.ready && !interlock;

	always_comb begin
		uopNext.opcode = condPass ? opCmd : exPkg::NOP;	// Squash failed predicate
		uopNext.ixt = opIxt;
		uopNext.srcA = opSrcA;
		uopNext.srcB = opSrcB;
		uopNext.srcC = opSrcC;
		uopNext.imm = opImm;
		uopNext.dest = opDest;
		uopNext.writesFlag = (uopNext.opcode == exPkg::CMPEQ)
			|| (uopNext.opcode == exPkg::CMPGT);
		uopNext.isMem = (uopNext.opcode == exPkg::LOAD) || (uopNext.opcode == exPkg::STORE);
		uopNext.isMul = (uopNext.opcode == exPkg::MUL);
	end

	always_ff @(posedge clock) begin
		if (rst)
			dValid <= 1'b0;
		else if (uopOut.ready)
			dValid <= opValid && opReady;	// Bubble while interlocked
	end

	always_ff @(posedge clock) begin
		if (uopOut.ready)
			dUop <= uopNext;
	end

	assign uopOut.valid = dValid;
	assign uopOut.payload = dUop;

endmodule

`default_nettype wire

/* hdl/exStageIf.sv */
/*
	Stage-to-stage bundles
	exUopIf carries decoded micro-ops into EX1,
	exExecIf carries EX1 results into EX2
	Both are valid/ready with a struct payload
*/
`default_nettype none

interface exUopIf;

	logic valid;	// Source has a micro-op
	logic ready;	// Sink takes it this edge
	exPkg::exUop payload;

	modport source(output valid, output payload, input ready);
	modport sink(input valid, input payload, output ready);

endinterface

interface exExecIf;

	logic valid;	// EX1 result present
	logic ready;	// EX2 not holding
	exPkg::exExec payload;

	modport source(output valid, output payload, input ready);
	modport sink(input valid, input payload, output ready);

endinterface

`default_nettype wire

/* hdl/exPkg.sv */
/*
	Integer execute back end definitions
	Data path widths, micro-op and predicate encodings,
	and the payloads carried between the pipeline stages
*/
`default_nettype none

package exPkg;

	localparam int dataWidth = 64;	// Data path width
	localparam int regIdWidth = 6;	// Destination register id
	localparam int immWidth = 33;	// Immediate from decode

	typedef enum logic [3:0] {
		NOP,	// Also used for a failed predicate
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		MOVI,	// Sign-extended immediate
		CMPEQ,
		CMPGT,	// Signed compare
		LOAD,
		STORE,
		MUL	// 32x32, ixt picks destination
	} exOpcode;

	typedef enum logic [1:0] {
		ALWAYS,
		NEVER,
		IFTRUE,	// Run when T set
		IFFALSE	// Run when T clear
	} exCond;

	typedef struct packed {
		exOpcode opcode;
		logic [1:0] ixt;	// Sub-mode
		logic [dataWidth-1:0] srcA;	// ALU A, base
		logic [dataWidth-1:0] srcB;	// ALU B, index
		logic [dataWidth-1:0] srcC;	// Store data
		logic [immWidth-1:0] imm;
		logic [regIdWidth-1:0] dest;
		logic writesFlag;	// Compare class
		logic isMem;	// Load or store
		logic isMul;
	} exUop;

	typedef struct packed {
		exOpcode opcode;
		logic [1:0] ixt;
		logic [regIdWidth-1:0] dest;
		logic [dataWidth-1:0] aluRes;
		logic cmpFlag;
		logic [dataWidth-1:0] product;	// Full 64-bit product
		logic isLoad;
		logic isMul;
	} exExec;

endpackage

`default_nettype wire
